/* source/exec_settings.svh */
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// Width of every data word that moves through the execute stage.
`define EXEC_NB_DATA 32

// Width of a register number in the 32-entry register file.
`define EXEC_NB_REG 5

// Register that jal writes its link address into.
`define EXEC_LINK_REG 31

`endif

/* source/mips_isa_pkg.sv */
`include "exec_settings.svh"

// Types that come straight from the instruction encoding.
package mips_isa_pkg;

	// Primary opcode field, bits 31 to 26 of the instruction word.
	typedef enum logic [5:0] {
		R_TYPE = 6'h00,
		JAL    = 6'h03,
		ADDI   = 6'h08,
		ADDIU  = 6'h09,
		SLTI   = 6'h0A,
		SLTIU  = 6'h0B,
		ANDI   = 6'h0C,
		ORI    = 6'h0D,
		XORI   = 6'h0E,
		LUI    = 6'h0F,
		LW     = 6'h23,
		SW     = 6'h2B
	} opcode_t;

	// Function field of an R-type instruction, bits 5 to 0.
	typedef enum logic [5:0] {
		SLL  = 6'h00,
		SRL  = 6'h02,
		SRA  = 6'h03,
		ADD  = 6'h20,
		ADDU = 6'h21,
		SUB  = 6'h22,
		SUBU = 6'h23,
		AND  = 6'h24,
		OR   = 6'h25,
		XOR  = 6'h26,
		NOR  = 6'h27,
		SLT  = 6'h2A,
		SLTU = 6'h2B
	} funct_t;

	// Register number as it appears in the rs, rt and rd fields.
	typedef logic [`EXEC_NB_REG-1:0] reg_addr_t;

	// Shift amount field, bits 10 to 6.
	typedef logic [4:0] shamt_t;

endpackage

/* source/exec_types_pkg.sv */
`include "exec_settings.svh"

// Types that belong to the execute datapath rather than to the encoding.
package exec_types_pkg;

	// One datapath word, used for operands, results and store data.
	typedef logic [`EXEC_NB_DATA-1:0] word_t;

	// Operation that the ALU carries out on its two operands.
	typedef enum logic [3:0] {
		ADD,
		SUB,
		AND,
		OR,
		XOR,
		NOR,
		SLT,
		SLTU,
		SLL,
		SRL,
		SRA,
		LUI,
		PASS_B
	} alu_op_t;

	// Source of a forwarded operand.
	typedef enum logic [1:0] {
		FWD_REG    = 2'd0,
		FWD_EX_MEM = 2'd1,
		FWD_MEM_WB = 2'd2
	} fwd_sel_t;

	// Field that names the destination register.
	// The encoding matches the regDest level of the ID/EX register.
	typedef enum logic [1:0] {
		DEST_RT   = 2'd0,
		DEST_RD   = 2'd1,
		DEST_LINK = 2'd2
	} reg_dest_t;

endpackage

/* source/pipe_result_if.sv */
`timescale 1ns/1ps

// One pipeline result as it travels from EX towards write-back.
// The same bundle is used at the EX output and in EX/MEM and MEM/WB.
interface pipe_result_if
	import mips_isa_pkg::*;
	import exec_types_pkg::*;
	();

	// Level that marks a real instruction in this slot.
	logic      valid;
	// Write enable for the register file, already qualified by valid.
	logic      reg_write;
	// Register that the result is written to.
	reg_addr_t write_reg;
	// ALU result, or the address for a load or store.
	word_t     result;
	// Forwarded rt value that a store writes to memory.
	word_t     store_data;

	// The stage that produces the result drives every field.
	modport producer (output valid, reg_write, write_reg, result, store_data);

	// Later stages and the forwarding logic only read the fields.
	modport consumer (input valid, reg_write, write_reg, result, store_data);

endinterface

/* source/alu_control.sv */
`timescale 1ns/1ps

// Maps the opcode, and for R-type instructions the funct field, to an ALU operation.
// Both packages name their codes after the same mnemonics, so literals are qualified.
module alu_control
	import mips_isa_pkg::*;
	import exec_types_pkg::*;
	(
		input  opcode_t opcode_i,
		input  funct_t  funct_i,
		output alu_op_t alu_op_o,
		output logic    use_shamt_o
	);

	always_comb begin
		// Anything that is not decoded below falls back to an add.
		alu_op_o    = exec_types_pkg::ADD;
		use_shamt_o = 1'b0;
		case (opcode_i)
			R_TYPE: begin
				case (funct_i)
					// The three fixed shifts take their amount from the shamt field.
					mips_isa_pkg::SLL: begin
						alu_op_o    = exec_types_pkg::SLL;
						use_shamt_o = 1'b1;
					end
					mips_isa_pkg::SRL: begin
						alu_op_o    = exec_types_pkg::SRL;
						use_shamt_o = 1'b1;
					end
					mips_isa_pkg::SRA: begin
						alu_op_o    = exec_types_pkg::SRA;
						use_shamt_o = 1'b1;
					end
					// Overflow traps are not taken, so the signed forms behave as the unsigned ones.
					mips_isa_pkg::ADD, ADDU: alu_op_o = exec_types_pkg::ADD;
					mips_isa_pkg::SUB, SUBU: alu_op_o = exec_types_pkg::SUB;
					mips_isa_pkg::AND:       alu_op_o = exec_types_pkg::AND;
					mips_isa_pkg::OR:        alu_op_o = exec_types_pkg::OR;
					mips_isa_pkg::XOR:       alu_op_o = exec_types_pkg::XOR;
					mips_isa_pkg::NOR:       alu_op_o = exec_types_pkg::NOR;
					mips_isa_pkg::SLT:       alu_op_o = exec_types_pkg::SLT;
					mips_isa_pkg::SLTU:      alu_op_o = exec_types_pkg::SLTU;
					default:                 alu_op_o = exec_types_pkg::ADD;
				endcase
			end
			// Loads and stores add the offset to the base register.
			ADDI, ADDIU, LW, SW: alu_op_o = exec_types_pkg::ADD;
			SLTI:                alu_op_o = exec_types_pkg::SLT;
			SLTIU:               alu_op_o = exec_types_pkg::SLTU;
			ANDI:                alu_op_o = exec_types_pkg::AND;
			ORI:                 alu_op_o = exec_types_pkg::OR;
			XORI:                alu_op_o = exec_types_pkg::XOR;
			mips_isa_pkg::LUI:   alu_op_o = exec_types_pkg::LUI;
			// The link address arrives on the immediate, so jal just passes operand B.
			JAL:                 alu_op_o = PASS_B;
			default:             alu_op_o = exec_types_pkg::ADD;
		endcase
	end

endmodule

/* source/alu.sv */
`timescale 1ns/1ps

// Combinational integer ALU of the execute stage.
module alu
	import exec_types_pkg::*;
	(
		input  word_t   a_i,
		input  word_t   b_i,
		input  alu_op_t op_i,
		output word_t   result_o
	);

	// Half a word, used by lui.
	localparam int HALF = $bits(word_t) / 2;
	// Number of low bits of operand A that form a shift distance.
	localparam int SHIFT_W = $clog2($bits(word_t));

	logic [SHIFT_W-1:0] shift;

	// Shifts move operand B, the distance comes from operand A.
	assign shift = a_i[SHIFT_W-1:0];

	always_comb begin
		case (op_i)
			ADD:    result_o = a_i + b_i;
			SUB:    result_o = a_i - b_i;
			AND:    result_o = a_i & b_i;
			OR:     result_o = a_i | b_i;
			XOR:    result_o = a_i ^ b_i;
			NOR:    result_o = ~(a_i | b_i);
			// Set on less than, as a two's complement compare.
			SLT:    result_o = word_t'($signed(a_i) < $signed(b_i));
			// Same compare with both operands taken as unsigned.
			SLTU:   result_o = word_t'(a_i < b_i);
			SLL:    result_o = b_i << shift;
			SRL:    result_o = b_i >> shift;
			// The arithmetic shift copies the sign bit into the vacated positions.
			SRA:    result_o = word_t'($signed(b_i) >>> shift);
			// The low half of the immediate goes to the upper half, the rest is zero.
			LUI:    result_o = {b_i[HALF-1:0], {HALF{1'b0}}};
			PASS_B: result_o = b_i;
			default: result_o = '0;
		endcase
	end

endmodule

/* source/forward_unit.sv */
`timescale 1ns/1ps

// Decides for rs and rt whether a newer result is still in flight.
// EX/MEM holds the newest result and so has priority over MEM/WB.
module forward_unit
	import mips_isa_pkg::*;
	import exec_types_pkg::*;
	(
		input  reg_addr_t              rs_i,
		input  reg_addr_t              rt_i,
		pipe_result_if.consumer        ex_mem_i,
		pipe_result_if.consumer        mem_wb_i,
		output fwd_sel_t               fwd_a_o,
		output fwd_sel_t               fwd_b_o
	);

	// Applies the forwarding rule to one source register.
	function automatic fwd_sel_t pick_source(input reg_addr_t src);
		fwd_sel_t sel;
		// Register 0 always reads as zero and is never forwarded.
		if (src != '0 && ex_mem_i.valid && ex_mem_i.reg_write &&
			ex_mem_i.write_reg == src) begin
			sel = FWD_EX_MEM;
		end else if (src != '0 && mem_wb_i.valid && mem_wb_i.reg_write &&
			mem_wb_i.write_reg == src) begin
			sel = FWD_MEM_WB;
		end else begin
			sel = FWD_REG;
		end
		return sel;
	endfunction

	// Operand A comes from rs.
	always_comb begin
		fwd_a_o = pick_source(rs_i);
	end

	// Operand B comes from rt and also feeds the store data.
	always_comb begin
		fwd_b_o = pick_source(rt_i);
	end

endmodule

/* source/execute_top.sv */
`timescale 1ns/1ps
`include "exec_settings.svh"

// Execute stage: forwarding, operand selection, the ALU and the destination register.
// The whole stage is combinational and EX/MEM sits in result_pipe.
module execute_top
	import mips_isa_pkg::*;
	import exec_types_pkg::*;
	(
		input  opcode_t         opcode_i,
		input  funct_t          funct_i,
		input  shamt_t          shamt_i,
		input  reg_addr_t       rs_i,
		input  reg_addr_t       rt_i,
		input  reg_addr_t       rd_i,
		input  word_t           data_ra_i,
		input  word_t           data_rb_i,
		input  word_t           inmediate_i,
		input  logic            tipeI_i,
		input  reg_dest_t       regDest_signal_i,
		input  logic            reg_write_i,
		input  logic            valid_i,
		pipe_result_if.consumer ex_mem_i,
		pipe_result_if.consumer mem_wb_i,
		pipe_result_if.producer ex_out_o
	);

	fwd_sel_t  fwd_a;
	fwd_sel_t  fwd_b;
	alu_op_t   alu_op;
	logic      use_shamt;
	word_t     fwd_ra;
	word_t     fwd_rb;
	word_t     alu_a;
	word_t     alu_b;
	word_t     alu_result;
	reg_addr_t write_reg;

	// Picks the register-file value or one of the two results in flight.
	function automatic word_t forward_mux(input fwd_sel_t sel, input word_t reg_value);
		word_t value;
		case (sel)
			FWD_EX_MEM: value = ex_mem_i.result;
			FWD_MEM_WB: value = mem_wb_i.result;
			default:    value = reg_value;
		endcase
		return value;
	endfunction

	forward_unit forward_unit_i (
		.rs_i     (rs_i),
		.rt_i     (rt_i),
		.ex_mem_i (ex_mem_i),
		.mem_wb_i (mem_wb_i),
		.fwd_a_o  (fwd_a),
		.fwd_b_o  (fwd_b)
	);

	alu_control alu_control_i (
		.opcode_i    (opcode_i),
		.funct_i     (funct_i),
		.alu_op_o    (alu_op),
		.use_shamt_o (use_shamt)
	);

	// Register values after forwarding, for rs and rt.
	always_comb begin
		fwd_ra = forward_mux(fwd_a, data_ra_i);
		fwd_rb = forward_mux(fwd_b, data_rb_i);
	end

	// Fixed shifts take the zero-extended shamt field instead of rs.
	assign alu_a = use_shamt ? word_t'(shamt_i) : fwd_ra;

	// I-type instructions replace rt with the prepared immediate.
	assign alu_b = tipeI_i ? inmediate_i : fwd_rb;

	alu alu_i (
		.a_i      (alu_a),
		.b_i      (alu_b),
		.op_i     (alu_op),
		.result_o (alu_result)
	);

	// The unused code 3 falls back to rt.
	always_comb begin
		case (regDest_signal_i)
			DEST_RD:   write_reg = rd_i;
			DEST_LINK: write_reg = reg_addr_t'(`EXEC_LINK_REG);
			default:   write_reg = rt_i;
		endcase
	end

	// A bubble never writes the register file.
	assign ex_out_o.valid      = valid_i;
	assign ex_out_o.reg_write  = reg_write_i & valid_i;
	assign ex_out_o.write_reg  = write_reg;
	assign ex_out_o.result     = alu_result;
	// The store data is rt after forwarding and does not depend on the immediate select.
	assign ex_out_o.store_data = fwd_rb;

endmodule

/* source/result_pipe.sv */
`timescale 1ns/1ps

// EX/MEM and MEM/WB result registers.
// MEM/WB carries the ALU result unchanged, since the memory access is not modelled.
module result_pipe (
	input  logic            clk_i,
	input  logic            rst_n_i,
	pipe_result_if.consumer ex_out_i,
	pipe_result_if.producer ex_mem_o,
	pipe_result_if.producer mem_wb_o
);

	// The pipeline advances every cycle, nothing can hold a stage.
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ex_mem_o.valid      <= 1'b0;
			ex_mem_o.reg_write  <= 1'b0;
			ex_mem_o.write_reg  <= '0;
			ex_mem_o.result     <= '0;
			ex_mem_o.store_data <= '0;
		end else begin
			ex_mem_o.valid      <= ex_out_i.valid;
			ex_mem_o.reg_write  <= ex_out_i.reg_write;
			ex_mem_o.write_reg  <= ex_out_i.write_reg;
			ex_mem_o.result     <= ex_out_i.result;
			ex_mem_o.store_data <= ex_out_i.store_data;
		end
	end

	// Second stage, one edge behind EX/MEM.
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			mem_wb_o.valid      <= 1'b0;
			mem_wb_o.reg_write  <= 1'b0;
			mem_wb_o.write_reg  <= '0;
			mem_wb_o.result     <= '0;
			mem_wb_o.store_data <= '0;
		end else begin
			mem_wb_o.valid      <= ex_mem_o.valid;
			mem_wb_o.reg_write  <= ex_mem_o.reg_write;
			mem_wb_o.write_reg  <= ex_mem_o.write_reg;
			mem_wb_o.result     <= ex_mem_o.result;
			mem_wb_o.store_data <= ex_mem_o.store_data;
		end
	end

endmodule

/* source/exec_subsystem_top.sv */
`timescale 1ns/1ps

// Execute stage with its EX/MEM and MEM/WB registers.
// The outputs show EX/MEM, one clock after the instruction was presented.
module exec_subsystem_top
	import mips_isa_pkg::*;
	import exec_types_pkg::*;
	(
		input  logic      clk_i,
		input  logic      rst_n_i,
		input  opcode_t   opcode_i,
		input  funct_t    funct_i,
		input  shamt_t    shamt_i,
		input  reg_addr_t rs_i,
		input  reg_addr_t rt_i,
		input  reg_addr_t rd_i,
		input  word_t     data_ra_i,
		input  word_t     data_rb_i,
		input  word_t     inmediate_i,
		input  logic      tipeI_i,
		input  reg_dest_t regDest_signal_i,
		input  logic      reg_write_i,
		input  logic      valid_i,
		output logic      valid_o,
		output logic      reg_write_o,
		output reg_addr_t write_reg_o,
		output word_t     alu_result_o,
		output word_t     data_rb_o
	);

	// Combinational stage output, then the two registered copies.
	pipe_result_if ex_out ();
	pipe_result_if ex_mem ();
	pipe_result_if mem_wb ();

	execute_top execute_top_i (
		.opcode_i         (opcode_i),
		.funct_i          (funct_i),
		.shamt_i          (shamt_i),
		.rs_i             (rs_i),
		.rt_i             (rt_i),
		.rd_i             (rd_i),
		.data_ra_i        (data_ra_i),
		.data_rb_i        (data_rb_i),
		.inmediate_i      (inmediate_i),
		.tipeI_i          (tipeI_i),
		.regDest_signal_i (regDest_signal_i),
		.reg_write_i      (reg_write_i),
		.valid_i          (valid_i),
		.ex_mem_i         (ex_mem.consumer),
		.mem_wb_i         (mem_wb.consumer),
		.ex_out_o         (ex_out.producer)
	);

	result_pipe result_pipe_i (
		.clk_i    (clk_i),
		.rst_n_i  (rst_n_i),
		.ex_out_i (ex_out.consumer),
		.ex_mem_o (ex_mem.producer),
		.mem_wb_o (mem_wb.producer)
	);

	assign valid_o      = ex_mem.valid;
	assign reg_write_o  = ex_mem.reg_write;
	assign write_reg_o  = ex_mem.write_reg;
	assign alu_result_o = ex_mem.result;
	assign data_rb_o    = ex_mem.store_data;

endmodule

/* test/tb_exec_subsystem.sv */
`timescale 1ns/1ps

// Streams test/exec_vectors.txt through the execute subsystem.
// Line k is presented on one rising edge and its EX/MEM result is compared after the next one.
module tb_exec_subsystem
	import mips_isa_pkg::*;
	import exec_types_pkg::*;
	();

	// Each vector line holds 13 input columns followed by 5 expected outputs.
	localparam int FIELDS        = 18;
	localparam int NUM_VECTORS   = 37;
	localparam int RESET_CYCLES  = 4;
	localparam int RESET_TIMEOUT = 20;
	// The stream needs about one cycle per line, plus the reset phase.
	localparam int RUN_TIMEOUT   = NUM_VECTORS + 40;

	logic      clk_i;
	logic      rst_n_i;
	opcode_t   opcode_i;
	funct_t    funct_i;
	shamt_t    shamt_i;
	reg_addr_t rs_i;
	reg_addr_t rt_i;
	reg_addr_t rd_i;
	word_t     data_ra_i;
	word_t     data_rb_i;
	word_t     inmediate_i;
	logic      tipeI_i;
	reg_dest_t regDest_signal_i;
	logic      reg_write_i;
	logic      valid_i;
	logic      valid_o;
	logic      reg_write_o;
	reg_addr_t write_reg_o;
	word_t     alu_result_o;
	word_t     data_rb_o;

	// All vector lines with one column per word.
	word_t     vec_mem [NUM_VECTORS*FIELDS];
	int        error_count;
	int        check_count;
	// Raised by the stream process once the last line has been compared.
	logic      stream_done = 1'b0;

	exec_subsystem_top exec_subsystem_top_i (
		.clk_i            (clk_i),
		.rst_n_i          (rst_n_i),
		.opcode_i         (opcode_i),
		.funct_i          (funct_i),
		.shamt_i          (shamt_i),
		.rs_i             (rs_i),
		.rt_i             (rt_i),
		.rd_i             (rd_i),
		.data_ra_i        (data_ra_i),
		.data_rb_i        (data_rb_i),
		.inmediate_i      (inmediate_i),
		.tipeI_i          (tipeI_i),
		.regDest_signal_i (regDest_signal_i),
		.reg_write_i      (reg_write_i),
		.valid_i          (valid_i),
		.valid_o          (valid_o),
		.reg_write_o      (reg_write_o),
		.write_reg_o      (write_reg_o),
		.alu_result_o     (alu_result_o),
		.data_rb_o        (data_rb_o)
	);

	// 10 ns clock.
	always #5 clk_i = ~clk_i;

	// Presents the input columns of one vector line.
	task automatic apply_vector(input int row);
		int base;
		base = row * FIELDS;
		opcode_i         <= opcode_t'(vec_mem[base][5:0]);
		funct_i          <= funct_t'(vec_mem[base + 1][5:0]);
		shamt_i          <= vec_mem[base + 2][4:0];
		rs_i             <= vec_mem[base + 3][4:0];
		rt_i             <= vec_mem[base + 4][4:0];
		rd_i             <= vec_mem[base + 5][4:0];
		data_ra_i        <= vec_mem[base + 6];
		data_rb_i        <= vec_mem[base + 7];
		inmediate_i      <= vec_mem[base + 8];
		tipeI_i          <= vec_mem[base + 9][0];
		regDest_signal_i <= reg_dest_t'(vec_mem[base + 10][1:0]);
		reg_write_i      <= vec_mem[base + 11][0];
		valid_i          <= vec_mem[base + 12][0];
	endtask

	// A bubble with every field at zero.
	task automatic park_inputs();
		opcode_i         <= R_TYPE;
		funct_i          <= funct_t'(6'h00);
		shamt_i          <= '0;
		rs_i             <= '0;
		rt_i             <= '0;
		rd_i             <= '0;
		data_ra_i        <= '0;
		data_rb_i        <= '0;
		inmediate_i      <= '0;
		tipeI_i          <= 1'b0;
		regDest_signal_i <= DEST_RT;
		reg_write_i      <= 1'b0;
		valid_i          <= 1'b0;
	endtask

	// Compares the EX/MEM outputs with the expected columns of one line.
	task automatic compare_results(input int row);
		int        base;
		logic      exp_valid;
		logic      exp_reg_write;
		reg_addr_t exp_write_reg;
		word_t     exp_result;
		word_t     exp_store;
		base          = row * FIELDS;
		exp_valid     = vec_mem[base + 13][0];
		exp_reg_write = vec_mem[base + 14][0];
		exp_write_reg = vec_mem[base + 15][4:0];
		exp_result    = vec_mem[base + 16];
		exp_store     = vec_mem[base + 17];
		check_count++;
		assert (valid_o == exp_valid) else begin
			$display("ERR %0t: line %0d valid_o %0b, expected %0b",
				$time, row, valid_o, exp_valid);
			error_count++;
		end
		assert (reg_write_o == exp_reg_write) else begin
			$display("ERR %0t: line %0d reg_write_o %0b, expected %0b",
				$time, row, reg_write_o, exp_reg_write);
			error_count++;
		end
		assert (write_reg_o == exp_write_reg) else begin
			$display("ERR %0t: line %0d write_reg_o %0d, expected %0d",
				$time, row, write_reg_o, exp_write_reg);
			error_count++;
		end
		assert (alu_result_o == exp_result) else begin
			$display("ERR %0t: line %0d alu_result_o %h, expected %h",
				$time, row, alu_result_o, exp_result);
			error_count++;
		end
		assert (data_rb_o == exp_store) else begin
			$display("ERR %0t: line %0d data_rb_o %h, expected %h",
				$time, row, data_rb_o, exp_store);
			error_count++;
		end
	endtask

	// Before any instruction has reached EX/MEM every output must be at its reset value.
	task automatic expect_quiet_outputs();
		check_count++;
		assert (valid_o == 1'b0 && reg_write_o == 1'b0) else begin
			$display("ERR %0t: valid_o %0b reg_write_o %0b, expected both low",
				$time, valid_o, reg_write_o);
			error_count++;
		end
		assert (write_reg_o == '0 && alu_result_o == '0 && data_rb_o == '0) else begin
			$display("ERR %0t: data outputs not zero after reset", $time);
			error_count++;
		end
	endtask

	// Stream process. Inputs change on the rising edge and outputs are read on the falling one.
	initial begin
		int wait_cycles;
		int row;
		wait_cycles = 0;
		while (rst_n_i !== 1'b1 && wait_cycles < RESET_TIMEOUT) begin
			@(negedge clk_i);
			wait_cycles++;
		end
		if (rst_n_i !== 1'b1) begin
			$display("Reset was still asserted after %0d cycles", RESET_TIMEOUT);
			error_count++;
		end else begin
			// Reset is released but no rising edge has followed yet.
			expect_quiet_outputs();
			for (row = 0; row <= NUM_VECTORS; row++) begin
				@(posedge clk_i);
				if (row < NUM_VECTORS) begin
					apply_vector(row);
				end else begin
					park_inputs();
				end
				@(negedge clk_i);
				// The first edge after reset only captures the idle inputs.
				if (row == 0) begin
					expect_quiet_outputs();
				end else begin
					compare_results(row - 1);
				end
			end
		end
		stream_done = 1'b1;
	end

	// Clock, reset, vector load and the final verdict.
	initial begin
		int wait_cycles;
		clk_i   = 1'b0;
		rst_n_i = 1'b0;
		park_inputs();
		$readmemh("test/exec_vectors.txt", vec_mem);
		repeat (RESET_CYCLES) @(posedge clk_i);
		rst_n_i <= 1'b1;
		wait_cycles = 0;
		while (!stream_done && wait_cycles < RUN_TIMEOUT) begin
			@(posedge clk_i);
			wait_cycles++;
		end
		if (!stream_done) begin
			$display("Vector stream did not finish within %0d cycles", RUN_TIMEOUT);
			error_count++;
		end
		$display("Comparisons: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

/* files.f */
+incdir+source
source/mips_isa_pkg.sv
source/exec_types_pkg.sv
source/pipe_result_if.sv
source/alu_control.sv
source/alu.sv
source/forward_unit.sv
source/execute_top.sv
source/result_pipe.sv
source/exec_subsystem_top.sv
test/tb_exec_subsystem.sv

/* Makefile */
# Verilator build and run of the execute subsystem testbench.

VERILATOR  ?= verilator
TOP        := tb_exec_subsystem
FILE_LIST  := files.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --assert -j 0 --Mdir $(OBJ_DIR) --top-module $(TOP)
LINT_FLAGS := --lint-only -Wall --timing --top-module $(TOP)
PASS_MSG   := All checks passed

.PHONY: all build run lint clean

# Build the simulator, run it and look for the pass line in its output.
all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILE_LIST)

clean:
	rm -rf $(OBJ_DIR)

/* test/exec_vectors.txt */
// op fn sh rs rt rd ra rb imm tipeI regDest reg_write valid, then expected
// valid_o reg_write_o write_reg_o alu_result_o data_rb_o. All columns are hex.
// Independent R-type operations, no source matches a result in flight.
00 20 00 01 02 0a 00000005 00000007 00000000 0 1 1 1  1 1 0a 0000000c 00000007
00 22 00 01 02 0b 00000003 00000005 00000000 0 1 1 1  1 1 0b fffffffe 00000005
00 23 00 03 04 0c 10000000 00000001 00000000 0 1 1 1  1 1 0c 0fffffff 00000001
00 24 00 01 02 0d f0f0f0f0 ff00ff00 00000000 0 1 1 1  1 1 0d f000f000 ff00ff00
00 25 00 01 02 0e f0f0f0f0 0f0f0000 00000000 0 1 1 1  1 1 0e fffff0f0 0f0f0000
00 26 00 01 02 0f ffff0000 0f0f0f0f 00000000 0 1 1 1  1 1 0f f0f00f0f 0f0f0f0f
00 27 00 01 02 10 0000f0f0 00000f0f 00000000 0 1 1 1  1 1 10 ffff0000 00000f0f
00 2a 00 01 02 11 ffffffff 00000001 00000000 0 1 1 1  1 1 11 00000001 00000001
00 2b 00 01 02 12 ffffffff 00000001 00000000 0 1 1 1  1 1 12 00000000 00000001
00 21 00 01 02 13 7fffffff 00000001 00000000 0 1 1 1  1 1 13 80000000 00000001
// Fixed shifts use shamt, the rs value of 1 must be ignored.
00 00 08 01 02 14 00000001 00abcdef 00000000 0 1 1 1  1 1 14 abcdef00 00abcdef
00 02 04 01 02 15 00000001 f0000000 00000000 0 1 1 1  1 1 15 0f000000 f0000000
00 03 04 01 02 16 00000001 f0000000 00000000 0 1 1 1  1 1 16 ff000000 f0000000
// I-type operations with the immediate on operand B, then jal, lw and regDest 3.
08 00 00 01 17 00 00000064 11111111 fffffff6 1 0 1 1  1 1 17 0000005a 11111111
0a 00 00 01 18 00 ffffffff 22222222 00000005 1 0 1 1  1 1 18 00000001 22222222
0b 00 00 01 19 00 00000001 33333333 ffffffff 1 0 1 1  1 1 19 00000001 33333333
0c 00 00 02 1a 00 12345678 44444444 0000ff00 1 0 1 1  1 1 1a 00005600 44444444
0d 00 00 02 1b 00 12340000 55555555 00005678 1 0 1 1  1 1 1b 12345678 55555555
0e 00 00 02 1c 00 0000ffff 66666666 00000f0f 1 0 1 1  1 1 1c 0000f0f0 66666666
0f 00 00 00 1d 00 00000000 77777777 0000abcd 1 0 1 1  1 1 1d abcd0000 77777777
03 00 00 00 00 00 00000000 00000000 00400010 1 2 1 1  1 1 1f 00400010 00000000
23 00 00 03 1e 00 10000000 88888888 00000008 1 0 1 1  1 1 1e 10000008 88888888
00 20 00 01 05 09 00000001 00000002 00000000 0 3 1 1  1 1 05 00000003 00000002
// Forwarding from EX/MEM on A, from MEM/WB on B, then EX/MEM winning over MEM/WB.
08 00 00 01 06 00 00000010 99999999 00000100 1 0 1 1  1 1 06 00000110 99999999
00 20 00 06 02 07 aaaaaaaa 00000001 00000000 0 1 1 1  1 1 07 00000111 00000001
00 22 00 02 06 08 00001000 bbbbbbbb 00000000 0 1 1 1  1 1 08 00000ef0 00000110
0d 00 00 00 08 00 00000000 cccccccc 00000055 1 0 1 1  1 1 08 00000055 00000ef0
00 20 00 08 08 09 dddddddd eeeeeeee 00000000 0 1 1 1  1 1 09 000000aa 00000055
// A write to r0 is never forwarded, nor is a result with reg_write low.
08 00 00 01 00 00 00000005 00000000 00000003 1 0 1 1  1 1 00 00000008 00000000
00 20 00 00 09 0a 00000000 ffff0000 00000000 0 1 1 1  1 1 0a 000000aa 000000aa
00 20 00 01 02 0c 00000100 00000200 00000000 0 1 0 1  1 0 0c 00000300 00000200
00 20 00 0c 01 0d 00000007 00000001 00000000 0 1 1 1  1 1 0d 00000008 00000001
// Store with forwarded data, then bubbles that must not forward.
2b 00 00 03 0d 00 20000000 34343434 00000010 1 0 0 1  1 0 0d 20000010 00000008
08 00 00 01 0e 00 00000001 00000000 00000001 1 0 1 0  0 0 0e 00000002 00000000
00 20 00 0e 0e 0f 00000030 00000040 00000000 0 1 1 1  1 1 0f 00000070 00000040
00 20 00 0e 0f 10 00000005 99990000 00000000 0 1 1 1  1 1 10 00000075 00000070
00 00 00 00 00 00 00000000 00000000 00000000 0 0 0 0  0 0 00 00000000 00000000
